/* run_sim.sh */
#!/bin/sh
# Build and run the UART loopback testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f \
	--top-module tb_uart_loopback -o tb_uart_loopback; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_uart_loopback
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit "$status"
fi

exit 0

/* sim.f */
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_loopback.sv
testbench/tb_clock.sv
testbench/uart_loopback_props.sv
testbench/tb_uart_loopback.sv

/* testbench/tb_clock.sv */
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 100
) (
	output logic o_clk
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		o_clk = 1'b0;
	end

	always #(PERIOD_NS / 2) o_clk = ~o_clk;	// 50 ns high, 50 ns low

endmodule

`default_nettype wire

/* testbench/tb_uart_loopback.sv */
`default_nettype none

module tb_uart_loopback;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLOCKS_PER_BIT = 8;
	localparam int PARITY_ENABLED = 1;
	localparam int PARITY_ODD = 0;
	localparam int FRAME_BITS = 1 + uart_pkg::DATA_WIDTH + PARITY_ENABLED + 1;
	localparam int FRAME_CYCLES = FRAME_BITS * CLOCKS_PER_BIT;
	localparam int ROUND_TRIP_WORDS = 200;
	localparam int RANDOM_WORDS = 20;
	localparam int MAX_CYCLES =
		(ROUND_TRIP_WORDS + RANDOM_WORDS) * (FRAME_CYCLES + 20) + 1000;

	logic clk;
	logic reset;
	logic enable;
	uart_pkg::data_t tx_data;
	logic busy;
	logic serial_line;
	uart_pkg::data_t rx_data;
	logic data_valid;
	logic rx_error;

	integer seed;
	uart_pkg::data_t model_q[$];	// words accepted but not yet received
	uart_pkg::data_t sent_word;
	uart_pkg::data_t cur_word;	// word now on the line
	bit pending;	// last drive will be accepted at the next rising edge
	bit in_frame;
	int frame_cyc;
	int sent;
	int accepted;
	int valids;
	int cycle_count;
	string test_name;

	tb_clock #(.PERIOD_NS(100)) u_clock (.o_clk(clk));

	uart_loopback #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT),
		.PARITY_ENABLED(PARITY_ENABLED),
		.PARITY_ODD(PARITY_ODD)
	) dut (
		.clk(clk),
		.reset(reset),
		.i_enable(enable),
		.i_data(tx_data),
		.o_busy(busy),
		.o_serial_out(serial_line),
		.o_received_data(rx_data),
		.o_data_valid(data_valid),
		.o_rx_error(rx_error)
	);

	bind uart_loopback uart_loopback_props #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT),
		.PARITY_ENABLED(PARITY_ENABLED)
	) u_props (
		.clk(clk),
		.reset(reset),
		.i_busy(o_busy),
		.i_serial(o_serial_out),
		.i_data_valid(o_data_valid),
		.i_rx_error(o_rx_error)
	);

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			fail_run($sformatf("MISMATCH %s expected %0h actual %0h", name, expected, actual));
		end
	endtask

	// expected line level for bit k of a frame carrying w
	function automatic logic line_bit(input uart_pkg::data_t w, input int k);
		int ones;
		ones = 0;
		if (k == 0) begin
			return 1'b0;	// start
		end
		if (k <= uart_pkg::DATA_WIDTH) begin
			return w[k-1];	// lsb first
		end
		if (PARITY_ENABLED != 0 && k == uart_pkg::DATA_WIDTH + 1) begin
			for (int i = 0; i < uart_pkg::DATA_WIDTH; i++) begin
				if (w[i]) begin
					ones++;
				end
			end
			// count of ones including the parity bit is even for even parity
			return (ones % 2 == 1) ? (PARITY_ODD == 0) : (PARITY_ODD != 0);
		end
		return 1'b1;	// stop
	endfunction

	// one clock of checks on the falling edge
	task automatic observe();
		@(negedge clk);
		if (pending) begin
			model_q.push_back(sent_word);
			cur_word = sent_word;
			in_frame = 1'b1;
			frame_cyc = 0;
			accepted++;
		end else if (in_frame) begin
			frame_cyc++;
		end
		if (in_frame) begin
			if (frame_cyc < FRAME_CYCLES) begin
				check_value({test_name, " busy window"}, 32'd1, 32'(busy));
				if (frame_cyc % CLOCKS_PER_BIT == CLOCKS_PER_BIT / 2) begin	// bit centre
					check_value({test_name, " frame bit"},
						32'(line_bit(cur_word, frame_cyc / CLOCKS_PER_BIT)),
						32'(serial_line));
				end
			end else begin
				check_value({test_name, " busy fall"}, 32'd0, 32'(busy));
				in_frame = 1'b0;
			end
		end else begin
			check_value({test_name, " idle busy"}, 32'd0, 32'(busy));
			check_value({test_name, " idle line"}, 32'd1, 32'(serial_line));
		end
		check_value({test_name, " rx error"}, 32'd0, 32'(rx_error));
		if (data_valid) begin
			if (model_q.size() == 0) begin
				fail_run("a data valid pulse came with no word in flight");
			end else begin
				check_value({test_name, " received word"}, 32'(model_q.pop_front()),
					32'(rx_data));
				valids++;
			end
		end
	endtask

	// new inputs with fresh data every cycle
	task automatic drive(input bit want_enable);
		enable = want_enable;
		tx_data = uart_pkg::data_t'($random(seed));
		pending = want_enable && !busy;	// busy is stable until the next rising edge
		if (pending) begin
			sent_word = tx_data;
			sent++;
		end
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > MAX_CYCLES) begin
			fail_run($sformatf("timeout, the run did not finish within %0d cycles", MAX_CYCLES));
		end
	end

	initial begin
		seed = 32'hae473774;
		reset = 1'b1;
		enable = 1'b0;
		tx_data = '0;
		sent_word = '0;
		cur_word = '0;
		pending = 1'b0;
		in_frame = 1'b0;
		frame_cyc = 0;
		sent = 0;
		accepted = 0;
		valids = 0;
		cycle_count = 0;
		test_name = "reset";
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_value("reset busy", 32'd0, 32'(busy));
		check_value("reset valid", 32'd0, 32'(data_valid));
		check_value("reset error", 32'd0, 32'(rx_error));
		check_value("reset line", 32'd1, 32'(serial_line));
		reset = 1'b0;

		// back to back frames with stray enables while busy
		test_name = "round_trip";
		while (sent < ROUND_TRIP_WORDS) begin
			observe();
			if (busy) begin
				drive(($random(seed) & 32'h1) != 0);
			end else begin
				drive(1'b1);
			end
		end

		test_name = "random_enable";
		while (sent < ROUND_TRIP_WORDS + RANDOM_WORDS) begin
			observe();
			drive(($random(seed) & 32'h3) == 0);
		end

		test_name = "drain";
		while (pending || in_frame) begin
			observe();
			drive(1'b0);
		end

		check_value("valid count", 32'(accepted), 32'(valids));
		if (model_q.size() != 0) begin
			fail_run("some sent words were never received");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* testbench/uart_loopback_props.sv */
`default_nettype none

module uart_loopback_props #(
	parameter int CLOCKS_PER_BIT = 8,
	parameter int PARITY_ENABLED = 1
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_busy,
	input wire logic i_serial,
	input wire logic i_data_valid,
	input wire logic i_rx_error
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME_BITS = 1 + uart_pkg::DATA_WIDTH + PARITY_ENABLED + 1;
	localparam int FRAME_CYCLES = FRAME_BITS * CLOCKS_PER_BIT;
	// valid lands at the stop bit centre, seen through the synchronizer
	localparam int VALID_LAT = uart_pkg::NUM_SYNC + FRAME_CYCLES - CLOCKS_PER_BIT / 2;

	int busy_len;	// consecutive cycles with busy high

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_len <= 0;
		end else if (i_busy) begin
			busy_len <= busy_len + 1;
		end else begin
			busy_len <= 0;
		end
	end

	a_valid_error_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(i_data_valid && i_rx_error))
		else $error("data valid and rx error are high in the same cycle");

	a_valid_single_cycle: assert property (@(posedge clk) disable iff (reset)
		i_data_valid |=> !i_data_valid)
		else $error("data valid stayed high for more than one cycle");

	a_idle_line_high: assert property (@(posedge clk) disable iff (reset)
		!i_busy |-> i_serial)
		else $error("serial line is low while the transmitter is not busy");

	a_busy_full_frame: assert property (@(posedge clk) disable iff (reset)
		$fell(i_busy) |-> busy_len == FRAME_CYCLES)
		else $error("busy did not stay high for one whole frame");

	// also catches a valid that arrives after busy has dropped
	a_valid_latency: assert property (@(posedge clk) disable iff (reset)
		i_data_valid |-> (busy_len >= VALID_LAT - 2) && (busy_len <= VALID_LAT + 2))
		else $error("data valid came outside its expected window in the frame");

endmodule

`default_nettype wire

/* verilog/uart_loopback.sv */
`default_nettype none

module uart_loopback #(
	parameter int CLOCKS_PER_BIT = 8,
	parameter int PARITY_ENABLED = 1,
	parameter int PARITY_ODD = 0
) (
	input  logic clk,
	input  logic reset,
	input  logic i_enable,
	input  uart_pkg::data_t i_data,
	output logic o_busy,
	output logic o_serial_out,
	output uart_pkg::data_t o_received_data,
	output logic o_data_valid,
	output logic o_rx_error
);

	logic serial_line;	// tx output, looped straight into rx

	uart_tx #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT),
		.PARITY_ENABLED(PARITY_ENABLED),
		.PARITY_ODD(PARITY_ODD)
	) u_tx (
		.clk(clk),
		.reset(reset),
		.i_enable(i_enable),
		.i_data(i_data),
		.o_busy(o_busy),
		.o_serial_out(serial_line)
	);

	uart_rx #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT),
		.PARITY_ENABLED(PARITY_ENABLED),
		.PARITY_ODD(PARITY_ODD)
	) u_rx (
		.clk(clk),
		.reset(reset),
		.i_serial_in(serial_line),
		.o_received_data(o_received_data),
		.o_data_valid(o_data_valid),
		.o_rx_error(o_rx_error)
	);

	assign o_serial_out = serial_line;

endmodule

`default_nettype wire

/* verilog/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	// data bits per frame
	localparam int DATA_WIDTH = 8;

	typedef logic [DATA_WIDTH-1:0] data_t;

	// flops between the serial line and the receiver FSM
	localparam int NUM_SYNC = 3;

	// transmitter FSM
	typedef enum logic {
		TX_IDLE,	// line high and not busy
		TX_SEND		// frame shifting out
	} tx_state_t;

	// receiver FSM
	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,	// waiting for the start bit centre
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

endpackage

`default_nettype wire

/* verilog/uart_rx.sv */
`default_nettype none

module uart_rx #(
	parameter int CLOCKS_PER_BIT = 8,
	parameter int PARITY_ENABLED = 1,
	parameter int PARITY_ODD = 0
) (
	input  logic clk,
	input  logic reset,
	input  logic i_serial_in,
	output uart_pkg::data_t o_received_data,
	output logic o_data_valid,
	output logic o_rx_error
);

	localparam int CNT_W = $clog2(CLOCKS_PER_BIT);
	localparam int IDX_W = $clog2(uart_pkg::DATA_WIDTH);
	localparam int HALF_BIT = CLOCKS_PER_BIT / 2;

	uart_pkg::rx_state_t state;

	logic [uart_pkg::NUM_SYNC-1:0] sync;	// sync[0] sees the raw line first
	logic line;	// synchronized serial line

	logic [CNT_W-1:0] clk_cnt;
	logic [IDX_W-1:0] bit_idx;	// data bit being sampled
	uart_pkg::data_t data_sr;	// lsb arrives first, shifted in from the top
	logic parity_r;	// sampled parity bit

	logic half_done;
	logic full_done;
	logic parity_ok;
	logic frame_ok;

	assign line = sync[uart_pkg::NUM_SYNC-1];

	assign half_done = (clk_cnt == CNT_W'(HALF_BIT - 1));
	assign full_done = (clk_cnt == CNT_W'(CLOCKS_PER_BIT - 1));

	// parity computed over the received word, checked only when enabled
	assign parity_ok = (PARITY_ENABLED == 0) || (parity_r == ((^data_sr) ^ (PARITY_ODD != 0)));
	assign frame_ok = parity_ok && line;	// line holds the stop bit at its centre

	// synchronizer, preset high so reset does not look like a start bit
	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= '1;
		end else begin
			sync <= {sync[uart_pkg::NUM_SYNC-2:0], i_serial_in};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uart_pkg::RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			o_data_valid <= 1'b0;
			o_rx_error <= 1'b0;
		end else begin
			o_data_valid <= 1'b0;	// both are one-cycle pulses
			o_rx_error <= 1'b0;
			case (state)
				uart_pkg::RX_IDLE: begin
					bit_idx <= '0;
					if (!line) begin
						state <= uart_pkg::RX_START;
						clk_cnt <= CNT_W'(1);	// detection cycle counts toward the half bit
					end else begin
						clk_cnt <= '0;
					end
				end
				uart_pkg::RX_START: begin
					if (half_done) begin
						clk_cnt <= '0;
						if (!line) begin
							state <= uart_pkg::RX_DATA;
						end else begin
							state <= uart_pkg::RX_IDLE;	// glitch, not a real start bit
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				uart_pkg::RX_DATA: begin
					if (full_done) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == IDX_W'(uart_pkg::DATA_WIDTH - 1)) begin
							if (PARITY_ENABLED != 0) begin
								state <= uart_pkg::RX_PARITY;
							end else begin
								state <= uart_pkg::RX_STOP;
							end
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				uart_pkg::RX_PARITY: begin
					if (full_done) begin
						clk_cnt <= '0;
						state <= uart_pkg::RX_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				uart_pkg::RX_STOP: begin
					if (full_done) begin
						clk_cnt <= '0;
						state <= uart_pkg::RX_IDLE;
						o_data_valid <= frame_ok;
						o_rx_error <= !frame_ok;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					state <= uart_pkg::RX_IDLE;
				end
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (state == uart_pkg::RX_DATA && full_done) begin
			data_sr <= {line, data_sr[uart_pkg::DATA_WIDTH-1:1]};
		end
		if (state == uart_pkg::RX_PARITY && full_done) begin
			parity_r <= line;
		end
		if (state == uart_pkg::RX_STOP && full_done && frame_ok) begin
			o_received_data <= data_sr;	// held until the next good frame
		end
	end

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
`default_nettype none

module uart_tx #(
	parameter int CLOCKS_PER_BIT = 8,
	parameter int PARITY_ENABLED = 1,
	parameter int PARITY_ODD = 0
) (
	input  logic clk,
	input  logic reset,
	input  logic i_enable,
	input  uart_pkg::data_t i_data,
	output logic o_busy,
	output logic o_serial_out
);

	// start + data + optional parity + stop
	localparam int FRAME_BITS = 1 + uart_pkg::DATA_WIDTH + PARITY_ENABLED + 1;
	localparam int CNT_W = $clog2(CLOCKS_PER_BIT);
	localparam int BIT_W = $clog2(FRAME_BITS);

	uart_pkg::tx_state_t state;

	logic [CNT_W-1:0] clk_cnt;	// cycles spent in the current bit
	logic [BIT_W-1:0] bit_cnt;	// index of the bit on the line
	logic [FRAME_BITS-1:0] shift_reg;	// bit 0 is the bit on the line
	logic [FRAME_BITS-1:0] frame;	// frame built from i_data

	logic bit_done;
	logic last_bit;

	// frame layout with the lsb going out first
	generate
		if (PARITY_ENABLED != 0) begin : g_parity
			logic parity_bit;

			assign parity_bit = (^i_data) ^ (PARITY_ODD != 0);
			assign frame = {1'b1, parity_bit, i_data, 1'b0};
		end else begin : g_no_parity
			assign frame = {1'b1, i_data, 1'b0};
		end
	endgenerate

	assign bit_done = (clk_cnt == CNT_W'(CLOCKS_PER_BIT - 1));
	assign last_bit = (bit_cnt == BIT_W'(FRAME_BITS - 1));

	assign o_busy = (state == uart_pkg::TX_SEND);

	// control path
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uart_pkg::TX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			o_serial_out <= 1'b1;	// idle line is high
		end else begin
			case (state)
				uart_pkg::TX_IDLE: begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					o_serial_out <= 1'b1;
					if (i_enable) begin
						state <= uart_pkg::TX_SEND;
						o_serial_out <= frame[0];	// start bit goes out right away
					end
				end
				uart_pkg::TX_SEND: begin
					if (bit_done) begin
						clk_cnt <= '0;
						if (last_bit) begin
							state <= uart_pkg::TX_IDLE;	// stop bit has run its full period
							o_serial_out <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							o_serial_out <= shift_reg[1];
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					state <= uart_pkg::TX_IDLE;
				end
			endcase
		end
	end

	// frame shift register
	always_ff @(posedge clk) begin
		if (state == uart_pkg::TX_IDLE) begin
			if (i_enable) begin
				shift_reg <= frame;
			end
		end else if (bit_done) begin
			shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};	// fill with idle level
		end
	end

endmodule

`default_nettype wire
